// ==== Makefile ====
TOP := tb_plat_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== host_chan_if.sv ====
`include "plat_defines.svh"

// One four-phase req/ack memory channel
interface host_chan_if;

    // Request side, held stable by the master while req is high
    logic                         req;
    plat_pkg::mem_op_e            op;
    logic [`PLAT_ADDR_WIDTH-1:0]  addr;
    logic [`PLAT_DATA_WIDTH-1:0]  wdata;

    // Response side, rdata is only meaningful while ack is high on a read
    logic                         ack;
    logic [`PLAT_DATA_WIDTH-1:0]  rdata;

    // The requester drives the command and waits for ack
    modport master (
        output req, op, addr, wdata,
        input  ack, rdata
    );

    // The responder answers with ack and read data
    modport slave (
        input  req, op, addr, wdata,
        output ack, rdata
    );

endinterface

// ==== host_chan_mux.sv ====
`include "plat_defines.svh"

module host_chan_mux
    import plat_pkg::*;
#(
    parameter int NUM_PORTS = `PLAT_NUM_PORTS
)
(
    input  logic        pClk,
    input  logic        rst_n,
    host_chan_if.slave  ports [NUM_PORTS],
    host_chan_if.master mem
);

    // Index width, kept at one bit even for a single port
    localparam int PW = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    mux_state_e                  state;
    logic [PW-1:0]               grant;
    logic [PW-1:0]               rr_ptr;
    logic [PW-1:0]               pick;
    logic [PW-1:0]               pick_next;
    logic [NUM_PORTS-1:0]        req_vec;
    logic [NUM_PORTS-1:0]        ack_vec;
    mem_op_e                     op_arr    [NUM_PORTS];
    logic [`PLAT_ADDR_WIDTH-1:0] addr_arr  [NUM_PORTS];
    logic [`PLAT_DATA_WIDTH-1:0] wdata_arr [NUM_PORTS];

    // Interface arrays only take constant indices, so flatten them here
    // Responses go back only to the granted port, every other port sees zero
    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_port
        assign req_vec[i]     = ports[i].req;
        assign op_arr[i]      = ports[i].op;
        assign addr_arr[i]    = ports[i].addr;
        assign wdata_arr[i]   = ports[i].wdata;
        assign ack_vec[i]     = (state != MUX_IDLE) && (grant == PW'(i)) && mem.ack;
        assign ports[i].ack   = ack_vec[i];
        assign ports[i].rdata = ack_vec[i] ? mem.rdata : '0;
    end

    // Round-robin search starting at the priority pointer
    // Walking backwards lets the lowest offset win
    always_comb
    begin
        int unsigned idx;
        pick = rr_ptr;
        for (int k = NUM_PORTS - 1; k >= 0; k--)
        begin
            idx = (int'(rr_ptr) + k) % NUM_PORTS;
            if (req_vec[idx])
                pick = PW'(idx);
        end
    end

    // Pointer moves to the port after the one being granted
    assign pick_next = (pick == PW'(NUM_PORTS - 1)) ? '0 : pick + 1'b1;

    // The shared req is only passed while BUSY, so a port that re-raises
    // req during DRAIN cannot start a new memory access early
    assign mem.req   = (state == MUX_BUSY) && req_vec[grant];
    assign mem.op    = op_arr[grant];
    assign mem.addr  = addr_arr[grant];
    assign mem.wdata = wdata_arr[grant];

    always_ff @(posedge pClk)
    begin
        if (!rst_n)
        begin
            state  <= MUX_IDLE;
            grant  <= '0;
            rr_ptr <= '0;
        end
        else
        begin
            case (state)
                MUX_IDLE:
                begin
                    if (req_vec != '0)
                    begin
                        grant  <= pick;
                        rr_ptr <= pick_next;
                        state  <= MUX_BUSY;
                    end
                end
                // Wait until the granted port has seen ack and dropped req
                MUX_BUSY:
                begin
                    if (mem.ack && !req_vec[grant])
                        state <= MUX_DRAIN;
                end
                // Hold the grant until the memory has lowered ack
                MUX_DRAIN:
                begin
                    if (!mem.ack)
                        state <= MUX_IDLE;
                end
                default:
                    state <= MUX_IDLE;
            endcase
        end
    end

    // Every shared ack reaches exactly one granted port
    a_one_grant: assert property (@(posedge pClk) disable iff (!rst_n)
        mem.ack |-> $onehot(ack_vec));

    // The grant is frozen while the shared channel is in use
    a_grant_stable: assert property (@(posedge pClk) disable iff (!rst_n)
        (mem.req || mem.ack) |=> $stable(grant));

endmodule

// ==== local_mem_model.sv ====
`include "plat_defines.svh"

module local_mem_model
    import plat_pkg::*;
(
    input  logic       pClk,
    input  logic       rst_n,
    host_chan_if.slave chan
);

    localparam int DEPTH = 1 << `PLAT_ADDR_WIDTH;
    localparam int CW    = $clog2(`PLAT_MEM_LATENCY + 1);

    mem_state_e                  state;
    logic [CW-1:0]               lat_cnt;
    logic                        fire;
    logic [`PLAT_DATA_WIDTH-1:0] mem [DEPTH];
    logic [`PLAT_DATA_WIDTH-1:0] rdata_q;

    // Last latency cycle, the access happens here and ack follows
    assign fire = (state == MEM_WAIT) && (lat_cnt == '0);

    // Ack is held through ACK and the one release cycle after req drops
    assign chan.ack   = (state == MEM_ACK) || (state == MEM_RELEASE);
    assign chan.rdata = rdata_q;

    always_ff @(posedge pClk)
    begin
        if (!rst_n)
        begin
            state   <= MEM_IDLE;
            lat_cnt <= '0;
        end
        else
        begin
            case (state)
                MEM_IDLE:
                begin
                    if (chan.req)
                    begin
                        lat_cnt <= CW'(`PLAT_MEM_LATENCY - 1);
                        state   <= MEM_WAIT;
                    end
                end
                MEM_WAIT:
                begin
                    if (fire)
                        state <= MEM_ACK;
                    else
                        lat_cnt <= lat_cnt - 1'b1;
                end
                // The requester drops req once it has seen ack
                MEM_ACK:
                begin
                    if (!chan.req)
                        state <= MEM_RELEASE;
                end
                MEM_RELEASE:
                    state <= MEM_IDLE;
                default:
                    state <= MEM_IDLE;
            endcase
        end
    end

    // Storage keeps its contents across resets, only the access is gated
    always_ff @(posedge pClk)
    begin
        if (rst_n && fire)
        begin
            if (chan.op == OP_WRITE)
                mem[chan.addr] <= chan.wdata;
            else
                rdata_q <= mem[chan.addr];
        end
    end

    // Ack may only rise in answer to a request held at the previous edge
    a_ack_needs_req: assert property (@(posedge pClk) disable iff (!rst_n)
        $rose(chan.ack) |-> $past(chan.req));

endmodule

// ==== plat_defines.svh ====
`ifndef PLAT_DEFINES_SVH
`define PLAT_DEFINES_SVH

// Number of AFU request ports that share the single memory channel
`define PLAT_NUM_PORTS 2

// Width of a word address into the local memory model
`define PLAT_ADDR_WIDTH 8

// Width of one memory word
`define PLAT_DATA_WIDTH 32

// Cycles from the memory model sampling req high to raising ack
`define PLAT_MEM_LATENCY 3

// Extra cycles the platform reset is held after every reset cause is gone
`define PLAT_RESET_HOLD 8

`endif

// ==== plat_pkg.sv ====
package plat_pkg;

    // Operation carried on a host channel request
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // Arbiter states, DRAIN waits for the shared ack to fall before a new grant
    typedef enum logic [1:0] {
        MUX_IDLE,
        MUX_BUSY,
        MUX_DRAIN
    } mux_state_e;

    // Memory model sequencing through one four-phase exchange
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT,
        MEM_ACK,
        MEM_RELEASE
    } mem_state_e;

endpackage

// ==== plat_reset_gen.sv ====
`include "plat_defines.svh"

module plat_reset_gen
(
    input  logic pClk,
    input  logic rst_n,
    input  logic soft_reset,
    output logic plat_rst_n
);

    // Counter wide enough to hold the full stretch length
    localparam int CW = $clog2(`PLAT_RESET_HOLD + 1);

    logic [CW-1:0] hold_cnt;

    // Any reset cause reloads the counter and forces the platform reset low
    // The counter then runs down once both causes are released
    always_ff @(posedge pClk)
    begin
        if (!rst_n || soft_reset)
        begin
            hold_cnt   <= CW'(`PLAT_RESET_HOLD);
            plat_rst_n <= 1'b0;
        end
        else if (hold_cnt != '0)
        begin
            hold_cnt   <= hold_cnt - 1'b1;
            plat_rst_n <= 1'b0;
        end
        else
        begin
            // Release only after the full hold has elapsed
            plat_rst_n <= 1'b1;
        end
    end

    // A soft reset request must reach the platform on the very next cycle
    a_soft_reset_applies: assert property (@(posedge pClk) soft_reset |=> !plat_rst_n);

endmodule

// ==== plat_top.sv ====
`include "plat_defines.svh"

module plat_top
    import plat_pkg::*;
(
    input  logic                        pClk,
    input  logic                        rst_n,
    input  logic                        soft_reset,
    input  logic                        port_req   [`PLAT_NUM_PORTS],
    input  mem_op_e                     port_op    [`PLAT_NUM_PORTS],
    input  logic [`PLAT_ADDR_WIDTH-1:0] port_addr  [`PLAT_NUM_PORTS],
    input  logic [`PLAT_DATA_WIDTH-1:0] port_wdata [`PLAT_NUM_PORTS],
    output logic                        port_ack   [`PLAT_NUM_PORTS],
    output logic [`PLAT_DATA_WIDTH-1:0] port_rdata [`PLAT_NUM_PORTS]
);

    // Platform reset shared by the arbiter and the memory model
    logic plat_rst_n;

    host_chan_if port_chan [`PLAT_NUM_PORTS] ();
    host_chan_if mem_chan ();

    plat_reset_gen u_reset_gen (
        .pClk,
        .rst_n,
        .soft_reset,
        .plat_rst_n
    );

    // Each AFU port becomes one channel into the arbiter
    for (genvar p = 0; p < `PLAT_NUM_PORTS; p++)
    begin : g_chan
        assign port_chan[p].req   = port_req[p];
        assign port_chan[p].op    = port_op[p];
        assign port_chan[p].addr  = port_addr[p];
        assign port_chan[p].wdata = port_wdata[p];
        assign port_ack[p]        = port_chan[p].ack;
        assign port_rdata[p]      = port_chan[p].rdata;
    end

    host_chan_mux #(
        .NUM_PORTS(`PLAT_NUM_PORTS)
    ) u_mux (
        .pClk,
        .rst_n (plat_rst_n),
        .ports (port_chan),
        .mem   (mem_chan)
    );

    local_mem_model u_mem (
        .pClk,
        .rst_n (plat_rst_n),
        .chan  (mem_chan)
    );

endmodule

// ==== plat_trace.txt ====
# tag mask then per port: op addr wdata exp_rdata (hex), op 0 reads and 1 writes
# mask bit n selects port n, a soft_reset line carries no other fields
wr_p0_a10  1  1 10 deadbeef 00000000  0 00 00000000 00000000
rd_p0_a10  1  0 10 00000000 deadbeef  0 00 00000000 00000000
wr_p1_a20  2  0 00 00000000 00000000  1 20 12345678 00000000
rd_p1_a20  2  0 00 00000000 00000000  0 20 00000000 12345678
rd_cross   3  0 20 00000000 12345678  0 10 00000000 deadbeef
wr_both    3  1 30 a5a5a5a5 00000000  1 31 5a5a5a5a 00000000
rd_both    3  0 30 00000000 a5a5a5a5  0 31 00000000 5a5a5a5a
rd_same    3  0 10 00000000 deadbeef  0 10 00000000 deadbeef
rr_wr_0    3  1 40 00000040 00000000  1 41 00000041 00000000
rr_rd_0    3  0 41 00000000 00000041  0 40 00000000 00000040
rr_wr_1    3  1 42 0000a042 00000000  1 43 0000b043 00000000
rr_rd_1    3  0 43 00000000 0000b043  0 42 00000000 0000a042
rr_mix     3  0 30 00000000 a5a5a5a5  1 44 44444444 00000000
soft_reset
post_rd_0  3  0 10 00000000 deadbeef  0 20 00000000 12345678
post_rd_1  1  0 30 00000000 a5a5a5a5  0 00 00000000 00000000
post_wr    2  0 00 00000000 00000000  1 50 cafef00d 00000000
post_rd_2  3  0 50 00000000 cafef00d  0 44 00000000 44444444

// ==== src.f ====
+incdir+.
plat_pkg.sv
host_chan_if.sv
plat_reset_gen.sv
host_chan_mux.sv
local_mem_model.sv
plat_top.sv
tb_plat_top.sv

// ==== tb_plat_top.sv ====
`include "plat_defines.svh"

module tb_plat_top
    import plat_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N  = `PLAT_NUM_PORTS;
    localparam int AW = `PLAT_ADDR_WIDTH;
    localparam int DW = `PLAT_DATA_WIDTH;

    logic          pClk = 1'b0;
    logic          rst_n;
    logic          soft_reset;
    logic          port_req   [N];
    mem_op_e       port_op    [N];
    logic [AW-1:0] port_addr  [N];
    logic [DW-1:0] port_wdata [N];
    logic          port_ack   [N];
    logic [DW-1:0] port_rdata [N];

    // One entry per trace line, port fields are flattened as line * N + port
    string         tag_q   [$];
    logic          soft_q  [$];
    logic [N-1:0]  mask_q  [$];
    mem_op_e       op_q    [$];
    logic [AW-1:0] addr_q  [$];
    logic [DW-1:0] wdata_q [$];
    logic [DW-1:0] exp_q   [$];

    // Observed and predicted order in which port acks rise
    int unsigned   ack_order [$];
    int unsigned   exp_order [$];
    int unsigned   rr_model;
    logic          ack_prev [N];
    int            ports_done;
    int            cycle_cnt = 0;
    int            cycle_limit = 200;

    plat_top DUT (
        .pClk       (pClk),
        .rst_n      (rst_n),
        .soft_reset (soft_reset),
        .port_req   (port_req),
        .port_op    (port_op),
        .port_addr  (port_addr),
        .port_wdata (port_wdata),
        .port_ack   (port_ack),
        .port_rdata (port_rdata)
    );

    always #2 pClk = ~pClk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [DW-1:0] expected,
                               input logic [DW-1:0] actual);
        if (expected !== actual)
            stop_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    // Counts from the first edge, the limit is set once the trace length is known
    always @(posedge pClk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
            stop_run($sformatf("Timeout, the trace did not finish in %0d cycles", cycle_limit));
    end

    // Only one port can be granted, so at most one ack rises per cycle
    always @(negedge pClk)
    begin
        for (int p = 0; p < N; p++)
        begin
            if (port_ack[p] && !ack_prev[p])
                ack_order.push_back(p);
            ack_prev[p] = port_ack[p];
        end
    end

    task automatic check_acks_low(input string name);
        for (int p = 0; p < N; p++)
            check_value($sformatf("%s port%0d ack", name, p), '0, DW'(port_ack[p]));
    endtask

    // Lines are a tag, a port mask, then op addr wdata exp_rdata for each port
    task automatic load_trace();
        int            fd;
        int            code;
        string         tag;
        string         rest;
        logic [N-1:0]  mask;
        logic [DW-1:0] f_op;
        logic [DW-1:0] f_addr;
        logic [DW-1:0] f_wdata;
        logic [DW-1:0] f_exp;
        fd = $fopen("plat_trace.txt", "r");
        if (fd == 0)
            stop_run("Cannot open the trace file plat_trace.txt");
        while ($fscanf(fd, "%s", tag) == 1)
        begin
            if (tag.substr(0, 0) == "#")
            begin
                code = $fgets(rest, fd);
                continue;
            end
            mask = '0;
            if (tag != "soft_reset" && $fscanf(fd, "%h", mask) != 1)
                stop_run($sformatf("Trace line %s has no port mask", tag));
            tag_q.push_back(tag);
            soft_q.push_back(tag == "soft_reset");
            mask_q.push_back(mask);
            for (int p = 0; p < N; p++)
            begin
                {f_op, f_addr, f_wdata, f_exp} = '0;
                code = 4;
                if (tag != "soft_reset")
                    code = $fscanf(fd, "%h %h %h %h", f_op, f_addr, f_wdata, f_exp);
                if (code != 4)
                    stop_run($sformatf("Trace line %s is missing fields for port %0d", tag, p));
                op_q.push_back(mem_op_e'(f_op[0]));
                addr_q.push_back(AW'(f_addr));
                wdata_q.push_back(f_wdata);
                exp_q.push_back(f_exp);
            end
        end
        $fclose(fd);
    endtask

    // One complete four-phase exchange on a single port
    task automatic run_port(input int p, input int e, input string tag);
        @(negedge pClk);
        port_op[p]    = op_q[e];
        port_addr[p]  = addr_q[e];
        port_wdata[p] = wdata_q[e];
        port_req[p]   = 1'b1;
        @(negedge pClk);
        while (port_ack[p] !== 1'b1)
            @(negedge pClk);
        if (op_q[e] == OP_READ)
            check_value($sformatf("%s port%0d rdata", tag, p), exp_q[e], port_rdata[p]);
        port_req[p] = 1'b0;
        while (port_ack[p] !== 1'b0)
            @(negedge pClk);
        ports_done++;
    endtask

    // Lines first to last share one port mask, each port runs its lines back to back
    task automatic run_group(input int first, input int last);
        int unsigned idx;
        int unsigned n_sel;
        n_sel = 0;
        for (int l = first; l <= last; l++)
        begin
            // Every selected port is still asking, so grants go in circular order from the pointer
            for (int k = 0; k < N; k++)
            begin
                idx = (rr_model + k) % N;
                if (mask_q[l][idx])
                begin
                    exp_order.push_back(idx);
                    n_sel++;
                end
            end
            if (mask_q[l] != '0)
                rr_model = (exp_order[$] + 1) % N;
        end
        ports_done = 0;
        for (int p = 0; p < N; p++)
        begin
            if (mask_q[first][p])
            begin
                fork
                    automatic int pp = p;
                    for (int l = first; l <= last; l++)
                        run_port(pp, l * N + pp, tag_q[l]);
                join_none
            end
        end
        wait (ports_done == int'(n_sel));
    endtask

    task automatic apply_soft_reset();
        @(negedge pClk);
        soft_reset = 1'b1;
        // Requests raised while the soft reset is active must never be answered
        for (int p = 0; p < N; p++)
            port_req[p] = 1'b1;
        repeat (2)
        begin
            @(negedge pClk);
            check_acks_low("soft_reset");
        end
        soft_reset = 1'b0;
        for (int p = 0; p < N; p++)
            port_req[p] = 1'b0;
        repeat (`PLAT_RESET_HOLD + 4)
        begin
            @(negedge pClk);
            check_acks_low("soft_reset_hold");
        end
        rr_model = 0;
    endtask

    initial
    begin
        int line_idx;
        int last_idx;
        rst_n      = 1'b0;
        soft_reset = 1'b0;
        rr_model   = 0;
        for (int p = 0; p < N; p++)
        begin
            port_req[p]   = 1'b0;
            port_op[p]    = OP_READ;
            port_addr[p]  = '0;
            port_wdata[p] = '0;
            ack_prev[p]   = 1'b0;
        end
        load_trace();
        cycle_limit = tag_q.size() * (N * (`PLAT_MEM_LATENCY + 6)) + 200;
        // The platform reset is registered, so the arbiter settles two edges in
        for (int c = 0; c < 16; c++)
        begin
            @(negedge pClk);
            if (c >= 2)
                check_acks_low("reset");
        end
        rst_n = 1'b1;
        repeat (`PLAT_RESET_HOLD + 4)
        begin
            @(negedge pClk);
            check_acks_low("reset_hold");
        end
        line_idx = 0;
        while (line_idx < tag_q.size())
        begin
            if (soft_q[line_idx])
            begin
                apply_soft_reset();
                line_idx++;
            end
            else
            begin
                // Consecutive lines on the same ports keep those ports requesting
                last_idx = line_idx;
                while (last_idx + 1 < tag_q.size() && !soft_q[last_idx + 1]
                       && mask_q[last_idx + 1] == mask_q[line_idx])
                    last_idx++;
                run_group(line_idx, last_idx);
                line_idx = last_idx + 1;
            end
        end
        check_value("ack_order_count", DW'(exp_order.size()), DW'(ack_order.size()));
        foreach (exp_order[i])
            check_value($sformatf("ack_order_%0d", i), DW'(exp_order[i]), DW'(ack_order[i]));
        $display("Everything OK");
        $finish;
    end

endmodule
